//--- hw/i2s_pkg.sv
// Shared types for the I2S/PDM transmit channel. Sample register is fixed at 32 bits
// Size code 01 has no meaning and must not be driven while the channel is enabled

package i2s_pkg;

    ////////////////////////////////////////////////////////////
    // Sample and counter types
    ////////////////////////////////////////////////////////////
    localparam int unsigned PACKET_SIZE = 32;

    typedef logic [PACKET_SIZE-1:0]         word_t;     // One sample as loaded
    typedef logic [$clog2(PACKET_SIZE)-1:0] bit_cnt_t;  // Bit position 0..31

    // Word length code, same encoding as the transfer size field
    typedef enum logic [1:0]
    {
        SIZE_8  = 2'b00,
        SIZE_16 = 2'b10,
        SIZE_32 = 2'b11
    } xfer_size_e;

    ////////////////////////////////////////////////////////////
    // Word length in bits for a size code
    ////////////////////////////////////////////////////////////
    function automatic logic [5:0] word_len(input xfer_size_e size);
        logic [5:0] len;
        case (size)
            SIZE_8:  len = 6'd8;
            SIZE_16: len = 6'd16;
            SIZE_32: len = 6'd32;
            default: len = 6'd32;   // Illegal code, treated as full word
        endcase
        return len;
    endfunction

endpackage

//--- hw/i2s_bclk_gen.sv
// Master-mode bit clock divider. CLK_DIV sck cycles per half bit period, CLK_DIV >= 1
// Strobes are combinational and line up with the edge at which bclk_o changes
`timescale 1ns/1ps

module i2s_bclk_gen
#(
    parameter int unsigned CLK_DIV = 2
)
(
    input  logic sck,
    input  logic rst,
    input  logic enable_i,
    output logic bclk_o,
    output logic bclk_rise_o,
    output logic bclk_fall_o
);

    localparam int unsigned DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt_q;
    logic             bclk_q;
    logic             toggle;

    // Half period elapsed
    assign toggle = enable_i && (div_cnt_q == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge sck, posedge rst)
    begin
        if (rst)
        begin
            div_cnt_q <= '0;
            bclk_q    <= 1'b0;
        end
        else if (!enable_i)
        begin
            div_cnt_q <= '0;   // Idle low, next enable starts with a rising edge
            bclk_q    <= 1'b0;
        end
        else if (toggle)
        begin
            div_cnt_q <= '0;
            bclk_q    <= ~bclk_q;
        end
        else
        begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    assign bclk_o      = bclk_q;
    assign bclk_rise_o = toggle & ~bclk_q;  // Register goes high at this edge
    assign bclk_fall_o = toggle &  bclk_q;  // Register goes low at this edge

endmodule

//--- hw/i2s_frame_ctrl.sv
// Bit and word framing on the falling bit clock edge. Size and PDM select
// must only change while enable_i is low
`timescale 1ns/1ps

module i2s_frame_ctrl
(
    input  logic                sck,
    input  logic                rst,
    input  logic                enable_i,
    input  logic                pdm_en_i,       // Word-select held low
    input  i2s_pkg::xfer_size_e transf_size_i,
    input  logic                bclk_fall_i,
    output logic                load_o,
    output logic                shift_o,
    output logic                ws_o,
    output logic                sample_req_o
);

    i2s_pkg::bit_cnt_t bit_cnt_q;      // Bit started at the next fall
    i2s_pkg::bit_cnt_t last_bit;
    logic              at_last;
    logic              ws_q;
    logic              sample_req_q;

    ////////////////////////////////////////////////////////////
    // Bit position within the word
    ////////////////////////////////////////////////////////////
    assign last_bit = i2s_pkg::bit_cnt_t'(i2s_pkg::word_len(transf_size_i) - 6'd1);
    assign at_last  = (bit_cnt_q == last_bit);

    always_ff @(posedge sck, posedge rst)
    begin
        if (rst)
        begin
            bit_cnt_q <= '0;
        end
        else if (!enable_i)
        begin
            bit_cnt_q <= '0;
        end
        else if (bclk_fall_i)
        begin
            if (at_last)
                bit_cnt_q <= '0;               // Wrap, next fall loads
            else
                bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    // Bit 0 takes a fresh sample, every other bit moves the register
    assign load_o  = bclk_fall_i && (bit_cnt_q == '0);
    assign shift_o = bclk_fall_i && (bit_cnt_q != '0);

    ////////////////////////////////////////////////////////////
    // Word select
    ////////////////////////////////////////////////////////////
    // Standard I2S: flips one bit ahead of the word boundary
    always_ff @(posedge sck, posedge rst)
    begin
        if (rst)
        begin
            ws_q <= 1'b0;
        end
        else if (!enable_i || pdm_en_i)
        begin
            ws_q <= 1'b0;
        end
        else if (bclk_fall_i && at_last)
        begin
            ws_q <= ~ws_q;
        end
    end

    assign ws_o = ws_q;

    ////////////////////////////////////////////////////////////
    // Sample request, one cycle behind the load
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sck, posedge rst)
    begin
        if (rst)
            sample_req_q <= 1'b0;
        else if (!enable_i)
            sample_req_q <= 1'b0;
        else
            sample_req_q <= load_o;
    end

    assign sample_req_o = sample_req_q;

    // Size code must be legal and must not move mid-transfer
    a_size_legal : assert property (
        @(posedge sck) disable iff (rst)
        enable_i |-> (transf_size_i inside {i2s_pkg::SIZE_8, i2s_pkg::SIZE_16,
                                            i2s_pkg::SIZE_32}));

    a_size_stable : assert property (
        @(posedge sck) disable iff (rst)
        (enable_i && $past(enable_i)) |-> $stable(transf_size_i));

endmodule

//--- hw/i2s_serializer.sv
// Parallel to serial converter, one bit per bit period. Bit order select
// must only change while the channel is disabled
`timescale 1ns/1ps

module i2s_serializer
(
    input  logic           sck,
    input  logic           rst,
    input  logic           enable_i,
    input  logic           load_i,         // Capture sample_i
    input  logic           shift_i,        // Advance one bit
    input  logic           lsb_first_i,
    input  i2s_pkg::word_t sample_i,
    output logic           data_o
);

    localparam int unsigned MSB = i2s_pkg::PACKET_SIZE - 1;

    i2s_pkg::word_t shift_q;

    ////////////////////////////////////////////////////////////
    // Shift register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sck, posedge rst)
    begin
        if (rst)
        begin
            shift_q <= '0;
        end
        else if (!enable_i)
        begin
            shift_q <= '0;                      // Line idles low
        end
        else if (load_i)
        begin
            shift_q <= sample_i;
        end
        else if (shift_i)
        begin
            if (lsb_first_i)
                shift_q <= {1'b0, shift_q[MSB:1]};   // Toward bit 0
            else
                shift_q <= {shift_q[MSB-1:0], 1'b0}; // Toward bit 31
        end
    end

    // Output bit sits at the end the register empties toward
    assign data_o = lsb_first_i ? shift_q[0] : shift_q[MSB];

    // Strobes come from frame control, a clash would drop a sample
    a_load_shift_excl : assert property (
        @(posedge sck) disable iff (rst) !(load_i && shift_i));

endmodule

//--- hw/i2s_tx_channel.sv
// I2S / PDM transmit channel, master mode only, single sck domain
// Source must hold sample_i from sample_req_o until the next word load
`timescale 1ns/1ps

module i2s_tx_channel
#(
    parameter int unsigned CLK_DIV = 2     // sck cycles per half bit period
)
(
    input  logic                sck,
    input  logic                rst,
    input  logic                enable_i,
    input  logic                pdm_en_i,
    input  logic                lsb_first_i,
    input  i2s_pkg::xfer_size_e transf_size_i,
    input  i2s_pkg::word_t      sample_i,
    output logic                bclk_o,
    output logic                ws_o,
    output logic                data_o,
    output logic                sample_req_o
);

    logic bclk_fall;
    logic load;
    logic shift;

    ////////////////////////////////////////////////////////////
    // Bit clock
    ////////////////////////////////////////////////////////////
    i2s_bclk_gen
    #(
        .CLK_DIV     (CLK_DIV)
    )
    i2s_bclk_gen_i
    (
        .sck         (sck),
        .rst         (rst),
        .enable_i    (enable_i),
        .bclk_o      (bclk_o),
        .bclk_rise_o (),             // Receiver edge, nothing to do on it here
        .bclk_fall_o (bclk_fall)
    );

    ////////////////////////////////////////////////////////////
    // Framing
    ////////////////////////////////////////////////////////////
    i2s_frame_ctrl i2s_frame_ctrl_i
    (
        .sck           (sck),
        .rst           (rst),
        .enable_i      (enable_i),
        .pdm_en_i      (pdm_en_i),
        .transf_size_i (transf_size_i),
        .bclk_fall_i   (bclk_fall),
        .load_o        (load),
        .shift_o       (shift),
        .ws_o          (ws_o),
        .sample_req_o  (sample_req_o)
    );

    // Data path
    i2s_serializer i2s_serializer_i
    (
        .sck         (sck),
        .rst         (rst),
        .enable_i    (enable_i),
        .load_i      (load),
        .shift_i     (shift),
        .lsb_first_i (lsb_first_i),
        .sample_i    (sample_i),
        .data_o      (data_o)
    );

endmodule

//--- include/tb_i2s_checks.svh
// Compare helpers for the transmit channel testbench, included inside its module
// Counters only ever grow, clear them by restarting the run
`ifndef TB_I2S_CHECKS_SVH
`define TB_I2S_CHECKS_SVH

int unsigned word_err_cnt = 0;  // Assembled word mismatches
int unsigned bit_err_cnt  = 0;  // Single level mismatches

// Received word against expected, both already masked to the word length
task automatic check_word(input i2s_pkg::word_t exp, input i2s_pkg::word_t act,
                          input string what);
    if (act !== exp)
    begin
        word_err_cnt++;
        $display("MISMATCH %s: expected %h, got %h at %0t", what, exp, act, $time);
    end
endtask

// ws_o and other one-bit levels
task automatic check_bit(input logic exp, input logic act, input string what);
    if (act !== exp)
    begin
        bit_err_cnt++;
        $display("MISMATCH %s: expected %b, got %b at %0t", what, exp, act, $time);
    end
endtask

function automatic int unsigned total_errors();
    return word_err_cnt + bit_err_cnt;
endfunction

`endif

//--- verification/tb_i2s_tx_channel.sv
// Directed tests for the transmit channel at CLK_DIV 2, master mode only
// Receiver samples data_o and ws_o at each rising bclk_o after the first fall
`timescale 1ns/1ps

module tb_i2s_tx_channel;

    localparam int unsigned CLK_DIV     = 2;
    // All words of all tests, the last test in three 16-bit segments of two words
    localparam int unsigned TOTAL_BITS  = 4*16 + 4*8 + 4*32 + 4*16 + 6*8 + 3*2*16;
    localparam int unsigned CYCLE_LIMIT = TOTAL_BITS * 2 * CLK_DIV * 2 + 200;

    logic                sck;
    logic                rst;
    logic                enable_i;
    logic                pdm_en_i;
    logic                lsb_first_i;
    i2s_pkg::xfer_size_e transf_size_i;
    i2s_pkg::word_t      sample_i;
    logic                bclk_o;
    logic                ws_o;
    logic                data_o;
    logic                sample_req_o;

    i2s_pkg::word_t tx_words[$];        // Source queue, index 0 preset
    i2s_pkg::word_t acc;                // Word being assembled
    logic [31:0]    lcg_state = 32'hf293;
    int             cfg_len;
    int             src_idx;
    int             rx_idx;
    int             bit_k;
    int             req_cnt;
    int             req_total;
    int unsigned    cycle_cnt = 0;
    int unsigned    cnt_err_cnt = 0;
    logic           cfg_lsb;
    logic           cfg_pdm;
    logic           started;
    logic           bclk_prev;
    logic           req_seen;
    logic           ws_exp;

    `include "tb_i2s_checks.svh"

    i2s_tx_channel #(.CLK_DIV(CLK_DIV)) i2s_tx_channel_i
    (
        .sck(sck), .rst(rst), .enable_i(enable_i), .pdm_en_i(pdm_en_i),
        .lsb_first_i(lsb_first_i), .transf_size_i(transf_size_i),
        .sample_i(sample_i), .bclk_o(bclk_o), .ws_o(ws_o),
        .data_o(data_o), .sample_req_o(sample_req_o)
    );

    initial
    begin
        sck = 1'b0;
        forever #10 sck = ~sck;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic i2s_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int size_bits(input i2s_pkg::xfer_size_e size);
        case (size)
            i2s_pkg::SIZE_8:  return 8;
            i2s_pkg::SIZE_16: return 16;
            default:          return 32;
        endcase
    endfunction

    // Bits a receiver should see, right aligned
    function automatic i2s_pkg::word_t expected_word(input i2s_pkg::word_t s);
        i2s_pkg::word_t mask;
        mask = '1;
        mask = mask >> (32 - cfg_len);
        if (cfg_lsb)
            return s & mask;
        return s >> (32 - cfg_len);
    endfunction

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp)
        begin
            cnt_err_cnt++;
            $display("MISMATCH %s: expected %0d, got %0d at %0t", what, exp, act, $time);
        end
    endtask

    task automatic check_idle(input string when);
        check_bit(1'b0, bclk_o, {"bclk_o ", when});
        check_bit(1'b0, ws_o, {"ws_o ", when});
        check_bit(1'b0, data_o, {"data_o ", when});
        check_bit(1'b0, sample_req_o, {"sample_req_o ", when});
    endtask

    ////////////////////////////////////////////////////////////
    // Receiver and source models
    ////////////////////////////////////////////////////////////
    always @(negedge sck)
    begin
        if (rst || !enable_i)
        begin
            started   = 1'b0;
            bclk_prev = 1'b0;
            bit_k     = 0;
            acc       = '0;
            req_cnt   = 0;
            req_seen  = 1'b0;
        end
        else
        begin
            if (sample_req_o)
            begin
                req_cnt++;
                req_total++;
                req_seen = 1'b1;
            end
            if (bclk_prev && !bclk_o)
                started = 1'b1;                 // First fall opens word 0
            else if (!bclk_prev && bclk_o && started)
            begin
                ws_exp = (rx_idx % 2 == 1);
                if (bit_k == cfg_len - 1)
                    ws_exp = ~ws_exp;           // Flips on the last bit
                check_bit(cfg_pdm ? 1'b0 : ws_exp, ws_o, "ws_o");
                if (cfg_lsb)
                    acc[bit_k] = data_o;
                else
                    acc = {acc[30:0], data_o};
                bit_k++;
                if (bit_k == cfg_len)
                begin
                    check_word(expected_word(tx_words[rx_idx]), acc, "received word");
                    check_count(1, req_cnt, "sample_req_o pulses in word");
                    rx_idx++;
                    bit_k   = 0;
                    acc     = '0;
                    req_cnt = 0;
                end
            end
            bclk_prev = bclk_o;
        end
    end

    always @(posedge sck)
    begin
        #2;
        if (req_seen)
        begin
            req_seen = 1'b0;
            src_idx++;
            sample_i = (src_idx < tx_words.size()) ? tx_words[src_idx] : lcg_next();
        end
    end

    always @(posedge sck)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d sck cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stream control
    ////////////////////////////////////////////////////////////
    task automatic prepare_stream(input i2s_pkg::xfer_size_e size, input logic lsb,
                                  input logic pdm, input int n);
        @(posedge sck);
        #2;
        tx_words.delete();
        repeat (n + 2) tx_words.push_back(lcg_next());
        cfg_len       = size_bits(size);
        cfg_lsb       = lsb;
        cfg_pdm       = pdm;
        rx_idx        = 0;
        src_idx       = 0;
        req_total     = 0;
        transf_size_i = size;
        lsb_first_i   = lsb;
        pdm_en_i      = pdm;
        sample_i      = tx_words[0];
    endtask

    task automatic run_stream(input int n);
        @(posedge sck);
        #2 enable_i = 1'b1;
        while (rx_idx < n)
            @(posedge sck);
        #2 enable_i = 1'b0;
        @(posedge sck);
    endtask

    // Start a stream and stop in word 1, where ws_o and bclk_o are high
    task automatic run_into_word_1();
        @(posedge sck);
        #2 enable_i = 1'b1;
        while (rx_idx < 1 || bit_k < 5)
            @(posedge sck);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic test_std_msb_16();
        prepare_stream(i2s_pkg::SIZE_16, 1'b0, 1'b0, 4);
        run_stream(4);
    endtask

    task automatic test_std_lsb_8();
        prepare_stream(i2s_pkg::SIZE_8, 1'b1, 1'b0, 4);
        run_stream(4);
    endtask

    task automatic test_std_msb_32_ws();
        prepare_stream(i2s_pkg::SIZE_32, 1'b0, 1'b0, 4);
        run_stream(4);
    endtask

    task automatic test_pdm_16();
        prepare_stream(i2s_pkg::SIZE_16, 1'b0, 1'b1, 4);
        run_stream(4);
    endtask

    task automatic test_sample_requests();
        prepare_stream(i2s_pkg::SIZE_8, 1'b0, 1'b0, 6);
        run_stream(6);
        check_count(6, req_total, "sample_req_o pulses in stream");
    endtask

    task automatic test_reset_disable();
        prepare_stream(i2s_pkg::SIZE_16, 1'b0, 1'b0, 3);
        run_into_word_1();
        #2;
        rst      = 1'b1;                        // Reset mid word, no clock edge yet
        enable_i = 1'b0;
        @(negedge sck);
        check_idle("during reset");
        repeat (2) @(posedge sck);
        #2 rst = 1'b0;
        @(negedge sck);
        check_idle("after reset");
        prepare_stream(i2s_pkg::SIZE_16, 1'b0, 1'b0, 3);
        run_into_word_1();
        #2 enable_i = 1'b0;                     // Drop mid word
        @(posedge sck);
        @(negedge sck);
        check_idle("after disable");
        prepare_stream(i2s_pkg::SIZE_16, 1'b0, 1'b0, 2);
        run_stream(2);
    endtask

    initial
    begin
        rst           = 1'b1;
        enable_i      = 1'b0;
        pdm_en_i      = 1'b0;
        lsb_first_i   = 1'b0;
        transf_size_i = i2s_pkg::SIZE_16;
        sample_i      = '0;
        repeat (2) @(posedge sck);
        #2 rst = 1'b0;

        test_std_msb_16();
        test_std_lsb_8();
        test_std_msb_32_ws();
        test_pdm_16();
        test_sample_requests();
        test_reset_disable();

        $display("Errors: %0d word, %0d bit, %0d count", word_err_cnt, bit_err_cnt,
                 cnt_err_cnt);
        if (total_errors() + cnt_err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/i2s_pkg.sv
hw/i2s_bclk_gen.sv
hw/i2s_frame_ctrl.sv
hw/i2s_serializer.sv
hw/i2s_tx_channel.sv
verification/tb_i2s_tx_channel.sv

//--- Bender.yml
package:
  name: i2s_tx_channel

sources:
  - files:
      - hw/i2s_pkg.sv
      - hw/i2s_bclk_gen.sv
      - hw/i2s_frame_ctrl.sv
      - hw/i2s_serializer.sv
      - hw/i2s_tx_channel.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_i2s_tx_channel.sv
